// ==== testbench/tmu_stimulus.txt ====
# columns: cmd a b, hex. W reg data, R reg expected, B stall_enable,
# D dst_word_adr expected_pixel, G runs the blit with the D lines before it.
R 00 0
R 06 280
R 07 1e0
R 0a 280
R 0b 1e0
R 01 20
R 02 18
R 03 3f
W 04 12345677
R 04 12345674
W 08 ffffffff
R 08 fffffffc
W 05 1001
R 05 1000
W 01 3
W 02 1
W 03 3f
W 05 1000
W 06 4
W 07 2
W 09 20000
W 0a 4
W 0b 2
R 09 20000
R 06 4
B 0
D 10000 525a
D 10001 525b
D 10002 5258
D 10003 5259
D 10004 525e
D 10005 525f
D 10006 525c
D 10007 525d
G
R 00 2
W 00 0
R 00 0
W 01 2
W 02 2
W 03 1f
W 05 2000
W 06 2
W 07 2
W 09 40000
W 0a 3
W 0b 3
B 1
D 20000 212d
D 20001 212d
D 20002 212d
D 20003 212d
D 20004 212d
D 20005 212d
D 20006 212c
D 20007 212c
D 20008 212c
G
R 00 2
W 00 0
R 00 0

// ==== files.f ====
+incdir+hw
hw/tmu_pkg.sv
hw/tmu_ctlif.sv
hw/tmu_meshgen.sv
hw/tmu_fetch.sv
hw/tmu_shade.sv
hw/tmu_perf.sv
hw/tmu_top.sv
testbench/tb_tmu.sv

// ==== Makefile ====
# Verilator build of the tmu testbench.

SIM = obj_dir/Vtb_tmu

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): files.f hw/*.sv hw/*.svh testbench/tb_tmu.sv
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_tmu -o Vtb_tmu

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== testbench/tb_tmu.sv ====
/* tmu testbench */
`timescale 1ns/1ps
`include "tmu_consts.svh"

module tb_tmu;

logic                sys_clk;
logic                sys_rst;
tmu_pkg::csr_adr_t   csr_a;
logic                csr_we;
tmu_pkg::csr_data_t  csr_di;
tmu_pkg::csr_data_t  csr_do;
logic                irq;
logic                tex_re;
tmu_pkg::fbuf_adr_t  tex_adr;
tmu_pkg::pix_t       tex_dat;
logic                tex_stall;
logic                dst_we;
tmu_pkg::fbuf_adr_t  dst_adr;
tmu_pkg::pix_t       dst_dat;
logic                dst_stall;

tmu_pkg::fbuf_adr_t exp_adr_q[$];   // pending destination writes.
tmu_pkg::pix_t exp_dat_q[$];
logic stall_win;                    // random stalls allowed while the DUT is busy.
logic stall_en;                     // current blit runs under stalls.
tmu_pkg::perf_t stall1_cnt;         // tex stalls seen while busy.
tmu_pkg::perf_t stall2_cnt;
tmu_pkg::perf_t hold_cnt;           // cycles with either port stalled.
tmu_pkg::perf_t reads_seen;         // texel reads accepted so far.
int total_writes;
int error_count;
int cycles;

tmu_top u_dut (.sys_clk, .sys_rst, .csr_a, .csr_we, .csr_di, .csr_do, .irq, .tex_re,
	.tex_adr, .tex_dat, .tex_stall, .dst_we, .dst_adr, .dst_dat, .dst_stall);

// texture memory returns a pattern of the word address.
assign tex_dat = tex_adr[15:0] ^ 16'h5a5a;

initial begin
	sys_clk = 1'b0;
	forever #2 sys_clk = ~sys_clk;   // 4 ns period.
end

task automatic stop_with_failure();
	$display("FAIL: see errors above");
	$fatal(1, "simulation stopped on failure");
endtask

task automatic check_csr(input string what, input tmu_pkg::csr_data_t got,
		input tmu_pkg::csr_data_t exp);
	if (got !== exp) begin
		error_count++;
		$display("Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
		stop_with_failure();
	end
endtask

task automatic check_pix(input tmu_pkg::fbuf_adr_t got_adr, input tmu_pkg::pix_t got_dat,
		input tmu_pkg::fbuf_adr_t exp_adr, input tmu_pkg::pix_t exp_dat);
	if (got_adr !== exp_adr || got_dat !== exp_dat) begin
		error_count++;
		$display("Error at %0t ns: write %h:%h, expected %h:%h", $time, got_adr, got_dat,
			exp_adr, exp_dat);
		stop_with_failure();
	end
endtask

task automatic check_perf(input string what, input tmu_pkg::perf_t got,
		input tmu_pkg::perf_t exp);
	if (got !== exp) begin
		error_count++;
		$display("Error at %0t ns: counter %s is %0d, expected %0d", $time, what, got, exp);
		stop_with_failure();
	end
endtask

// bus tasks are entered 1 ns after a rising edge.
task automatic csr_write(input logic [4:0] idx, input tmu_pkg::csr_data_t val);
	csr_a = {`TMU_CSR_ADDR, 5'd0, idx};
	csr_we = 1'b1;
	csr_di = val;
	@(posedge sys_clk);
	#1;
	csr_we = 1'b0;
endtask

task automatic csr_read(input logic [4:0] idx, output tmu_pkg::csr_data_t val);
	csr_a = {`TMU_CSR_ADDR, 5'd0, idx};
	csr_we = 1'b0;
	@(posedge sys_clk);
	#1;
	val = csr_do;                     // registered one cycle after the address.
endtask

task automatic read_perf(input logic [4:0] idx, input string what,
		input tmu_pkg::perf_t exp);
	tmu_pkg::csr_data_t val;
	csr_read(idx, val);
	check_perf(what, tmu_pkg::perf_t'(val), exp);
endtask

task automatic run_blit();
	tmu_pkg::csr_data_t val;
	tmu_pkg::perf_t n;
	n = tmu_pkg::perf_t'(exp_adr_q.size());
	stall1_cnt = '0;
	stall2_cnt = '0;
	hold_cnt = '0;
	csr_write(`TMU_REG_CTRL, 32'h1);
	@(posedge sys_clk);               // generator is busy from here on.
	stall_win = stall_en;
	#1;
	csr_read(`TMU_REG_CTRL, val);
	check_csr("status during blit", val, 32'h1);
	while (exp_adr_q.size() != 0 || !irq) begin
		@(posedge sys_clk);
	end
	#1;
	check_perf("texel reads", reads_seen, tmu_pkg::perf_t'(total_writes));
	read_perf(`TMU_REG_PERF_PIXELS, "pixels", n);
	read_perf(`TMU_REG_PERF_COMPL1, "complete1", n);
	read_perf(`TMU_REG_PERF_COMPL2, "complete2", n);
	read_perf(`TMU_REG_PERF_STALL1, "stall1", stall1_cnt);
	read_perf(`TMU_REG_PERF_STALL2, "stall2", stall2_cnt);
	// busy spans every point, three pipeline cycles and one drain cycle.
	read_perf(`TMU_REG_PERF_CLOCKS, "clocks", n + 32'd4 + hold_cnt);
	read_perf(`TMU_REG_PERF_MISSES, "misses", '0);
endtask

// stalls drawn here count at the next edge while busy is high.
always @(posedge sys_clk) begin
	#1;
	if (stall_win) begin
		tex_stall = ($urandom % 4) == 0;
		dst_stall = ($urandom % 4) == 0;
		stall1_cnt = stall1_cnt + tmu_pkg::perf_t'(tex_stall);
		stall2_cnt = stall2_cnt + tmu_pkg::perf_t'(dst_stall);
		hold_cnt = hold_cnt + tmu_pkg::perf_t'(tex_stall | dst_stall);
	end else begin
		tex_stall = 1'b0;
		dst_stall = 1'b0;
	end
end

// texel reads accepted by the memory model.
always @(posedge sys_clk) begin
	if (!sys_rst && tex_re && !tex_stall && !dst_stall) begin
		reads_seen = reads_seen + 1'b1;
	end
end

// a write counts only in a cycle without stall.
always @(posedge sys_clk) begin
	if (!sys_rst && dst_we && !tex_stall && !dst_stall) begin
		if (exp_adr_q.size() == 0) begin
			$display("the DUT wrote to %h although no write was expected", dst_adr);
			stop_with_failure();
		end else begin
			check_pix(dst_adr, dst_dat, exp_adr_q.pop_front(), exp_dat_q.pop_front());
			if (exp_adr_q.size() == 0) stall_win = 1'b0;   // last write is out.
		end
	end
end

// the watchdog limit grows with the writes listed so far.
initial begin
	cycles = 0;
	while (cycles <= 5000 + 2000 * total_writes) begin
		@(posedge sys_clk);
		cycles++;
	end
	$display("timeout: the run did not finish after %0d cycles", cycles);
	stop_with_failure();
end

initial begin
	int fd;
	int r;
	logic [63:0] tok;
	logic [1023:0] rest;
	logic [31:0] a;
	logic [31:0] b;
	tmu_pkg::csr_data_t val;
	sys_rst = 1'b1;
	csr_a = '0;
	csr_we = 1'b0;
	csr_di = '0;
	tex_stall = 1'b0;
	dst_stall = 1'b0;
	stall_win = 1'b0;
	stall_en = 1'b0;
	stall1_cnt = '0;
	stall2_cnt = '0;
	hold_cnt = '0;
	reads_seen = '0;
	total_writes = 0;
	error_count = 0;
	r = $urandom(32'h04420d2a);       // one seed for the whole run.
	repeat (10) @(posedge sys_clk);
	#1;
	sys_rst = 1'b0;
	fd = $fopen("testbench/tmu_stimulus.txt", "r");
	if (fd == 0) begin
		$display("could not open testbench/tmu_stimulus.txt");
		stop_with_failure();
	end
	while (!$feof(fd)) begin
		tok = '0;
		r = $fscanf(fd, "%s", tok);
		if (r != 1) begin
			tok = '0;                     // trailing blank space.
		end else if (tok == "#") begin
			r = $fgets(rest, fd);         // comment line.
		end else if (tok == "W") begin
			r = $fscanf(fd, "%h %h", a, b);
			csr_write(a[4:0], b);
		end else if (tok == "R") begin
			r = $fscanf(fd, "%h %h", a, b);
			csr_read(a[4:0], val);
			check_csr($sformatf("register %0d", a[4:0]), val, b);
		end else if (tok == "B") begin
			r = $fscanf(fd, "%h", a);
			stall_en = a[0];
		end else if (tok == "D") begin
			r = $fscanf(fd, "%h %h", a, b);
			exp_adr_q.push_back(tmu_pkg::fbuf_adr_t'(a));
			exp_dat_q.push_back(b[15:0]);
			total_writes++;
		end else if (tok == "G") begin
			run_blit();
		end else begin
			$display("unknown command in the stimulus file");
			stop_with_failure();
		end
	end
	$fclose(fd);
	if (error_count == 0) begin
		$display("PASS: all tests");
		$finish;
	end else begin
		stop_with_failure();
	end
end

endmodule

// ==== hw/tmu_top.sv ====
/* texture mapping unit */
`timescale 1ns/1ps

module tmu_top (
	input  logic                sys_clk,
	input  logic                sys_rst,
	input  tmu_pkg::csr_adr_t   csr_a,
	input  logic                csr_we,
	input  tmu_pkg::csr_data_t  csr_di,
	output tmu_pkg::csr_data_t  csr_do,
	output logic                irq,
	output logic                tex_re,
	output tmu_pkg::fbuf_adr_t  tex_adr,
	input  tmu_pkg::pix_t       tex_dat,
	input  logic                tex_stall,
	output logic                dst_we,
	output tmu_pkg::fbuf_adr_t  dst_adr,
	output tmu_pkg::pix_t       dst_dat,
	input  logic                dst_stall
);

logic start;
logic busy;
logic hold;
logic pipe_empty;
tmu_pkg::mesh_idx_t hmesh_last;
tmu_pkg::mesh_idx_t vmesh_last;
tmu_pkg::bright_t brightness;
tmu_pkg::fbuf_adr_t src_fbuf;
tmu_pkg::res_t src_hres;
tmu_pkg::res_t src_vres;
tmu_pkg::fbuf_adr_t dst_fbuf;
tmu_pkg::res_t dst_hres;
tmu_pkg::res_t dst_vres;
logic gen_valid;
tmu_pkg::fbuf_adr_t gen_src;
tmu_pkg::fbuf_adr_t gen_dst;
logic tex_valid;
tmu_pkg::pix_t texel;
tmu_pkg::fbuf_adr_t fetch_dst;
logic shade_busy;
tmu_pkg::perf_t perf_clocks;
tmu_pkg::perf_t perf_pixels;
tmu_pkg::perf_t perf_stall1;
tmu_pkg::perf_t perf_complete1;
tmu_pkg::perf_t perf_stall2;
tmu_pkg::perf_t perf_complete2;

assign hold = tex_stall | dst_stall;                       // freezes every stage.
assign pipe_empty = ~(tex_re | tex_valid | shade_busy);    // no point in flight.

tmu_ctlif u_ctlif (.sys_clk, .sys_rst, .csr_a, .csr_we, .csr_di, .csr_do, .irq,
	.start, .busy, .hmesh_last, .vmesh_last, .brightness, .src_fbuf, .src_hres,
	.src_vres, .dst_fbuf, .dst_hres, .dst_vres, .perf_pixels, .perf_clocks,
	.perf_stall1, .perf_complete1, .perf_stall2, .perf_complete2);

tmu_meshgen u_meshgen (.sys_clk, .sys_rst, .start, .hold, .pipe_empty, .hmesh_last,
	.vmesh_last, .src_fbuf, .src_hres, .src_vres, .dst_fbuf, .dst_hres, .dst_vres,
	.busy, .gen_valid, .gen_src, .gen_dst);

tmu_fetch u_fetch (.sys_clk, .sys_rst, .hold, .gen_valid, .gen_src, .gen_dst,
	.tex_dat, .tex_re, .tex_adr, .tex_valid, .texel, .fetch_dst);

tmu_shade u_shade (.sys_clk, .sys_rst, .hold, .brightness, .tex_valid, .texel,
	.fetch_dst, .dst_we, .dst_adr, .dst_dat, .shade_busy);

tmu_perf u_perf (.sys_clk, .sys_rst, .start, .busy, .tex_re, .tex_stall, .dst_we,
	.dst_stall, .perf_clocks, .perf_pixels, .perf_stall1, .perf_complete1,
	.perf_stall2, .perf_complete2);

endmodule

// ==== hw/tmu_perf.sv ====
/* tmu performance counters */
`timescale 1ns/1ps

module tmu_perf (
	input  logic            sys_clk,
	input  logic            sys_rst,
	input  logic            start,
	input  logic            busy,
	input  logic            tex_re,
	input  logic            tex_stall,
	input  logic            dst_we,
	input  logic            dst_stall,
	output tmu_pkg::perf_t  perf_clocks,
	output tmu_pkg::perf_t  perf_pixels,
	output tmu_pkg::perf_t  perf_stall1,
	output tmu_pkg::perf_t  perf_complete1,
	output tmu_pkg::perf_t  perf_stall2,
	output tmu_pkg::perf_t  perf_complete2
);

logic rd_ok;
logic wr_ok;

assign rd_ok = tex_re & ~tex_stall & ~dst_stall;   // read accepted.
assign wr_ok = dst_we & ~tex_stall & ~dst_stall;   // write accepted.

always_ff @(posedge sys_clk) begin
	if (sys_rst || start) begin
		perf_clocks <= '0;
		perf_pixels <= '0;
		perf_stall1 <= '0;
		perf_complete1 <= '0;
		perf_stall2 <= '0;
		perf_complete2 <= '0;
	end else begin
		if (busy) perf_clocks <= perf_clocks + 1'b1;
		if (wr_ok) perf_pixels <= perf_pixels + 1'b1;
		if (busy && tex_stall) perf_stall1 <= perf_stall1 + 1'b1;
		if (rd_ok) perf_complete1 <= perf_complete1 + 1'b1;
		if (busy && dst_stall) perf_stall2 <= perf_stall2 + 1'b1;
		if (wr_ok) perf_complete2 <= perf_complete2 + 1'b1;
	end
end

endmodule

// ==== hw/tmu_shade.sv ====
/* tmu brightness and write port */
`timescale 1ns/1ps

module tmu_shade (
	input  logic                sys_clk,
	input  logic                sys_rst,
	input  logic                hold,
	input  tmu_pkg::bright_t    brightness,
	input  logic                tex_valid,
	input  tmu_pkg::pix_t       texel,
	input  tmu_pkg::fbuf_adr_t  fetch_dst,
	output logic                dst_we,
	output tmu_pkg::fbuf_adr_t  dst_adr,
	output tmu_pkg::pix_t       dst_dat,
	output logic                shade_busy
);

logic [6:0] scale;          // brightness plus one in the range 1 to 64.
logic [11:0] r_prod;
logic [12:0] g_prod;
logic [11:0] b_prod;
tmu_pkg::pix_t shaded;

assign scale = {1'b0, brightness} + 7'd1;
assign r_prod = {7'd0, texel[15:11]} * {5'd0, scale};
assign g_prod = {7'd0, texel[10:5]} * {6'd0, scale};
assign b_prod = {7'd0, texel[4:0]} * {5'd0, scale};
// divide by 64 and keep the floor.
assign shaded = {r_prod[10:6], g_prod[11:6], b_prod[10:6]};

always_ff @(posedge sys_clk) begin
	if (sys_rst) begin
		dst_we <= 1'b0;
	end else if (!hold) begin
		dst_we <= tex_valid;     // write goes out next cycle.
	end
end

always_ff @(posedge sys_clk) begin
	if (!hold && tex_valid) begin
		dst_adr <= fetch_dst;
		dst_dat <= shaded;
	end
end

assign shade_busy = dst_we;  // write not yet accepted.

endmodule

// ==== hw/tmu_fetch.sv ====
/* tmu texel fetch */
`timescale 1ns/1ps

module tmu_fetch (
	input  logic                sys_clk,
	input  logic                sys_rst,
	input  logic                hold,
	input  logic                gen_valid,
	input  tmu_pkg::fbuf_adr_t  gen_src,
	input  tmu_pkg::fbuf_adr_t  gen_dst,
	input  tmu_pkg::pix_t       tex_dat,    // async read data.
	output logic                tex_re,
	output tmu_pkg::fbuf_adr_t  tex_adr,
	output logic                tex_valid,
	output tmu_pkg::pix_t       texel,
	output tmu_pkg::fbuf_adr_t  fetch_dst
);

tmu_pkg::fbuf_adr_t req_dst;   // destination riding along with the read.

always_ff @(posedge sys_clk) begin
	if (sys_rst) begin
		tex_re <= 1'b0;
		tex_valid <= 1'b0;
	end else if (!hold) begin
		tex_re <= gen_valid;       // read strobe one cycle after the point.
		tex_valid <= tex_re;       // read accepted this cycle.
	end
end

always_ff @(posedge sys_clk) begin
	if (!hold && gen_valid) begin
		tex_adr <= gen_src;
		req_dst <= gen_dst;
	end
	if (!hold && tex_re) begin
		texel <= tex_dat;          // data returns in the strobe cycle.
		fetch_dst <= req_dst;
	end
end

endmodule

// ==== hw/tmu_meshgen.sv ====
/* tmu point generator */
`timescale 1ns/1ps

module tmu_meshgen (
	input  logic                sys_clk,
	input  logic                sys_rst,
	input  logic                start,        // one-cycle start pulse.
	input  logic                hold,         // any port stalled.
	input  logic                pipe_empty,   // nothing left downstream.
	input  tmu_pkg::mesh_idx_t  hmesh_last,
	input  tmu_pkg::mesh_idx_t  vmesh_last,
	input  tmu_pkg::fbuf_adr_t  src_fbuf,
	input  tmu_pkg::res_t       src_hres,
	input  tmu_pkg::res_t       src_vres,
	input  tmu_pkg::fbuf_adr_t  dst_fbuf,
	input  tmu_pkg::res_t       dst_hres,
	input  tmu_pkg::res_t       dst_vres,
	output logic                busy,
	output logic                gen_valid,
	output tmu_pkg::fbuf_adr_t  gen_src,
	output tmu_pkg::fbuf_adr_t  gen_dst
);

tmu_pkg::gen_state_t state;
tmu_pkg::mesh_idx_t dx;          // destination x.
tmu_pkg::mesh_idx_t dy;          // destination y.
tmu_pkg::fbuf_adr_t dst_row;     // destination row offset.
tmu_pkg::res_t src_x;            // source x.
tmu_pkg::fbuf_adr_t src_row;     // source row offset.
tmu_pkg::res_t h_acc;            // horizontal error term.
tmu_pkg::res_t v_acc;            // vertical error term.
logic [11:0] h_sum;
logic [11:0] v_sum;
logic [11:0] h_wrap;
logic [11:0] v_wrap;
logic h_step;
logic v_step;
logic row_end;
logic last_pt;
logic advance;

assign h_sum = {1'b0, h_acc} + {1'b0, src_hres};
assign v_sum = {1'b0, v_acc} + {1'b0, src_vres};
assign h_wrap = h_sum - {1'b0, dst_hres};
assign v_wrap = v_sum - {1'b0, dst_vres};
assign h_step = h_sum >= {1'b0, dst_hres};   // source x moves on.
assign v_step = v_sum >= {1'b0, dst_vres};   // source row moves on.

assign row_end = dx == hmesh_last;
assign last_pt = row_end && (dy == vmesh_last);

assign busy = state != tmu_pkg::IDLE;
assign gen_valid = state == tmu_pkg::RUN;
assign advance = gen_valid && !hold;         // point taken by fetch.

assign gen_src = src_fbuf + src_row + tmu_pkg::fbuf_adr_t'(src_x);
assign gen_dst = dst_fbuf + dst_row + tmu_pkg::fbuf_adr_t'(dx);

always_ff @(posedge sys_clk) begin
	if (sys_rst) begin
		state <= tmu_pkg::IDLE;
	end else begin
		case (state)
			tmu_pkg::IDLE: begin
				if (start) state <= tmu_pkg::RUN;
			end
			tmu_pkg::RUN: begin
				if (advance && last_pt) state <= tmu_pkg::DRAIN;
			end
			tmu_pkg::DRAIN: begin
				if (pipe_empty) state <= tmu_pkg::IDLE;   // last write accepted.
			end
			default: state <= tmu_pkg::IDLE;
		endcase
	end
end

// walk counters are loaded on start.
always_ff @(posedge sys_clk) begin
	if (start && !busy) begin
		dx <= '0;
		dy <= '0;
		dst_row <= '0;
		src_x <= '0;
		src_row <= '0;
		h_acc <= '0;
		v_acc <= '0;
	end else if (advance) begin
		if (row_end) begin
			dx <= '0;                                 // back to column zero.
			src_x <= '0;
			h_acc <= '0;
			dy <= dy + 1'b1;
			dst_row <= dst_row + tmu_pkg::fbuf_adr_t'(dst_hres);
			v_acc <= v_step ? v_wrap[10:0] : v_sum[10:0];
			if (v_step) begin
				src_row <= src_row + tmu_pkg::fbuf_adr_t'(src_hres);
			end
		end else begin
			dx <= dx + 1'b1;
			h_acc <= h_step ? h_wrap[10:0] : h_sum[10:0];
			if (h_step) begin
				src_x <= src_x + 1'b1;
			end
		end
	end
end

a_no_hdown: assert property (@(posedge sys_clk) disable iff (sys_rst)
	start |-> src_hres <= dst_hres) else $error("horizontal downscaling requested");
a_no_vdown: assert property (@(posedge sys_clk) disable iff (sys_rst)
	start |-> src_vres <= dst_vres) else $error("vertical downscaling requested");

endmodule

// ==== hw/tmu_ctlif.sv ====
/* tmu control interface */
`timescale 1ns/1ps
`include "tmu_consts.svh"

module tmu_ctlif (
	input  logic                sys_clk,
	input  logic                sys_rst,

	input  tmu_pkg::csr_adr_t   csr_a,
	input  logic                csr_we,
	input  tmu_pkg::csr_data_t  csr_di,
	output tmu_pkg::csr_data_t  csr_do,

	output logic                irq,
	output logic                start,
	input  logic                busy,

	output tmu_pkg::mesh_idx_t  hmesh_last,
	output tmu_pkg::mesh_idx_t  vmesh_last,
	output tmu_pkg::bright_t    brightness,

	output tmu_pkg::fbuf_adr_t  src_fbuf,
	output tmu_pkg::res_t       src_hres,
	output tmu_pkg::res_t       src_vres,
	output tmu_pkg::fbuf_adr_t  dst_fbuf,
	output tmu_pkg::res_t       dst_hres,
	output tmu_pkg::res_t       dst_vres,

	input  tmu_pkg::perf_t      perf_pixels,
	input  tmu_pkg::perf_t      perf_clocks,
	input  tmu_pkg::perf_t      perf_stall1,
	input  tmu_pkg::perf_t      perf_complete1,
	input  tmu_pkg::perf_t      perf_stall2,
	input  tmu_pkg::perf_t      perf_complete2
);

tmu_pkg::mesh_adr_t src_mesh;   // kept for the mesh fetch stage.
tmu_pkg::mesh_adr_t dst_mesh;
logic old_busy;                 // busy delayed by one cycle.
logic trigger_irq;
logic csr_selected;

assign trigger_irq = old_busy & ~busy;                   // falling edge of busy.
assign csr_selected = csr_a[13:10] == `TMU_CSR_ADDR;

always_ff @(posedge sys_clk) begin
	if (sys_rst) begin
		old_busy <= 1'b0;
	end else begin
		old_busy <= busy;
	end
end

always_ff @(posedge sys_clk) begin
	if (sys_rst) begin
		csr_do <= '0;
		irq <= 1'b0;
		start <= 1'b0;
		hmesh_last <= `TMU_RST_HMESH;
		vmesh_last <= `TMU_RST_VMESH;
		brightness <= `TMU_RST_BRIGHT;
		src_mesh <= '0;
		src_fbuf <= '0;
		src_hres <= `TMU_RST_HRES;
		src_vres <= `TMU_RST_VRES;
		dst_mesh <= '0;
		dst_fbuf <= '0;
		dst_hres <= `TMU_RST_HRES;
		dst_vres <= `TMU_RST_VRES;
	end else begin
		if (trigger_irq) begin
			irq <= 1'b1;                                  // blit finished.
		end
		csr_do <= '0;                                     // zero when not selected.
		start <= 1'b0;                                    // start is a pulse.
		if (csr_selected) begin
			if (csr_we) begin
				case (csr_a[4:0])
					`TMU_REG_CTRL: begin
						start <= csr_di[0] & ~busy & ~start;  // ignored while running.
						irq <= 1'b0;                          // any ctrl write acks.
					end
					`TMU_REG_HMESH:    hmesh_last <= csr_di[6:0];
					`TMU_REG_VMESH:    vmesh_last <= csr_di[6:0];
					`TMU_REG_BRIGHT:   brightness <= csr_di[5:0];
					`TMU_REG_SRC_MESH: src_mesh <= csr_di[31:2];
					`TMU_REG_SRC_FBUF: src_fbuf <= csr_di[`TMU_FML_DEPTH-1:1];
					`TMU_REG_SRC_HRES: src_hres <= csr_di[10:0];
					`TMU_REG_SRC_VRES: src_vres <= csr_di[10:0];
					`TMU_REG_DST_MESH: dst_mesh <= csr_di[31:2];
					`TMU_REG_DST_FBUF: dst_fbuf <= csr_di[`TMU_FML_DEPTH-1:1];
					`TMU_REG_DST_HRES: dst_hres <= csr_di[10:0];
					`TMU_REG_DST_VRES: dst_vres <= csr_di[10:0];
					default: ;                                // counters are read only.
				endcase
			end
			case (csr_a[4:0])
				`TMU_REG_CTRL:        csr_do <= {30'd0, irq, busy};
				`TMU_REG_HMESH:       csr_do <= {25'd0, hmesh_last};
				`TMU_REG_VMESH:       csr_do <= {25'd0, vmesh_last};
				`TMU_REG_BRIGHT:      csr_do <= {26'd0, brightness};
				`TMU_REG_SRC_MESH:    csr_do <= {src_mesh, 2'b00};   // byte address.
				`TMU_REG_SRC_FBUF:    csr_do <= {{(32-`TMU_FML_DEPTH){1'b0}}, src_fbuf, 1'b0};
				`TMU_REG_SRC_HRES:    csr_do <= {21'd0, src_hres};
				`TMU_REG_SRC_VRES:    csr_do <= {21'd0, src_vres};
				`TMU_REG_DST_MESH:    csr_do <= {dst_mesh, 2'b00};
				`TMU_REG_DST_FBUF:    csr_do <= {{(32-`TMU_FML_DEPTH){1'b0}}, dst_fbuf, 1'b0};
				`TMU_REG_DST_HRES:    csr_do <= {21'd0, dst_hres};
				`TMU_REG_DST_VRES:    csr_do <= {21'd0, dst_vres};
				`TMU_REG_PERF_PIXELS: csr_do <= perf_pixels;
				`TMU_REG_PERF_CLOCKS: csr_do <= perf_clocks;
				`TMU_REG_PERF_STALL1: csr_do <= perf_stall1;
				`TMU_REG_PERF_COMPL1: csr_do <= perf_complete1;
				`TMU_REG_PERF_STALL2: csr_do <= perf_stall2;
				`TMU_REG_PERF_COMPL2: csr_do <= perf_complete2;
				`TMU_REG_PERF_MISSES: csr_do <= '0;           // no texel cache yet.
				default:              csr_do <= '0;
			endcase
		end
	end
end

// a new blit is only launched from an idle generator.
a_start_idle: assert property (@(posedge sys_clk) disable iff (sys_rst) !(start && busy))
	else $error("start pulse while the generator is busy");

endmodule

// ==== hw/tmu_pkg.sv ====
/* tmu types */
`include "tmu_consts.svh"

package tmu_pkg;

	typedef logic [13:0] csr_adr_t;                   // csr word address.
	typedef logic [31:0] csr_data_t;                  // csr data word.

	typedef logic [`TMU_FML_DEPTH-2:0] fbuf_adr_t;    // address in 16-bit words.
	typedef logic [29:0] mesh_adr_t;                  // mesh pointer in 32-bit words.

	typedef logic [10:0] res_t;                       // resolution or coordinate.
	typedef logic [6:0] mesh_idx_t;                   // last grid index.
	typedef logic [5:0] bright_t;                     // brightness where 63 is unity.

	typedef logic [15:0] pix_t;                       // rgb565 pixel.
	typedef logic [31:0] perf_t;                      // performance counter.

	// mesh generator states.
	typedef enum logic [1:0] {
		IDLE,     // waiting for start.
		RUN,      // emitting points.
		DRAIN     // waiting for the last write.
	} gen_state_t;

endpackage

// ==== hw/tmu_consts.svh ====
/* tmu constants */
`ifndef TMU_CONSTS_SVH
`define TMU_CONSTS_SVH

`define TMU_FML_DEPTH        26       // byte address depth of the memory.
`define TMU_CSR_ADDR         4'h0     // bank compared with csr_a[13:10].

`define TMU_REG_CTRL         5'd0     // start and status.
`define TMU_REG_HMESH        5'd1
`define TMU_REG_VMESH        5'd2
`define TMU_REG_BRIGHT       5'd3
`define TMU_REG_SRC_MESH     5'd4
`define TMU_REG_SRC_FBUF     5'd5
`define TMU_REG_SRC_HRES     5'd6
`define TMU_REG_SRC_VRES     5'd7
`define TMU_REG_DST_MESH     5'd8
`define TMU_REG_DST_FBUF     5'd9
`define TMU_REG_DST_HRES     5'd10
`define TMU_REG_DST_VRES     5'd11
`define TMU_REG_PERF_PIXELS  5'd12    // counters are read only.
`define TMU_REG_PERF_CLOCKS  5'd13
`define TMU_REG_PERF_STALL1  5'd14
`define TMU_REG_PERF_COMPL1  5'd15
`define TMU_REG_PERF_STALL2  5'd16
`define TMU_REG_PERF_COMPL2  5'd17
`define TMU_REG_PERF_MISSES  5'd18

`define TMU_RST_HRES         11'd640
`define TMU_RST_VRES         11'd480
`define TMU_RST_HMESH        7'd32
`define TMU_RST_VMESH        7'd24
`define TMU_RST_BRIGHT       6'd63

`endif
